// File: include/rom_load_cfg.svh
// rom loader configuration: image header layout, region offsets, key and fifo depth
`ifndef ROM_LOAD_CFG_SVH
`define ROM_LOAD_CFG_SVH

// image header layout, byte offsets from start of image
`define ROM_HEADER_LEN   64    // body byte 0 sits here
`define ROM_START_BYTES  6     // three 16-bit start positions
`define ROM_CFG_FIRST    8
`define ROM_CFG_LAST     39
`define ROM_CFG_BYTE     39    // bit 7 enables cpu decryption

// sdram word offsets per region
`define ROM_CPU_BASE     23'h000000
`define ROM_SND_BASE     23'h040000
`define ROM_PCM_BASE     23'h080000
`define ROM_GFX_BASE     23'h100000

// cpu byte decryption key, applied after a one bit left rotate
`define ROM_DECRYPT_KEY  8'h5a

// request buffer between mapper and sdram writer
`define PROG_FIFO_DEPTH  8

`endif

// File: rtl/rom_load_pkg.sv
// rom loader types: vector widths, pending sdram write and writer states
package rom_load_pkg;

    typedef logic [7:0]  byte_t;        // image or config byte
    typedef logic [25:0] ioctl_addr_t;  // host byte address
    typedef logic [22:0] prog_addr_t;   // sdram word address
    typedef logic [15:0] kb_start_t;    // region start in 1 KB units
    typedef logic [1:0]  bank_t;
    typedef logic [1:0]  mask_t;        // active low lane mask
    typedef logic [4:0]  cfg_addr_t;

    // one pending sdram write
    typedef struct packed {
        prog_addr_t addr;
        byte_t      data;
        mask_t      mask;
        bank_t      bank;
    } prog_req_t;

    // sdram programming writer
    typedef enum logic [0:0] {
        WR_IDLE = 1'b0,  // waiting for a request
        WR_WAIT = 1'b1   // prog_we high until prog_rdy
    } wr_state_e;

endpackage

// File: rtl/rom_region_mapper.sv
// rom region mapper: parses the image header and turns body bytes into sdram write requests
`timescale 1ns/1ns

`include "rom_load_cfg.svh"

module rom_region_mapper
    import rom_load_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_dout,
    input  logic        ioctl_wr,
    output logic        cfg_we,
    output cfg_addr_t   cfg_addr,
    output byte_t       cfg_data,
    output logic        push,
    output prog_req_t   req
);

    // start table, little endian 16-bit entries
    kb_start_t   snd_start;
    kb_start_t   pcm_start;
    kb_start_t   gfx_start;
    logic        decrypt;

    logic        wr_strobe;
    logic        is_start;
    logic        is_cfg;
    logic        is_body;
    ioctl_addr_t cfg_index;
    ioctl_addr_t body_off;      // offset from body byte 0
    kb_start_t   body_kb;
    ioctl_addr_t rel_off;       // offset inside the region

    kb_start_t   region_start;
    prog_addr_t  region_base;
    bank_t       region_bank;
    logic        is_cpu;
    byte_t       dec_byte;

    assign wr_strobe = downloading && ioctl_wr;
    assign is_start  = ioctl_addr < `ROM_START_BYTES;
    assign is_cfg    = ioctl_addr >= `ROM_CFG_FIRST && ioctl_addr <= `ROM_CFG_LAST;
    assign is_body   = ioctl_addr >= `ROM_HEADER_LEN;

    assign cfg_index = ioctl_addr - ioctl_addr_t'(`ROM_CFG_FIRST);
    assign body_off  = ioctl_addr - ioctl_addr_t'(`ROM_HEADER_LEN);
    assign body_kb   = body_off[25:10];

    // region select, ordered by start position
    always_comb begin
        is_cpu = 1'b0;
        if (body_kb < snd_start) begin
            region_start = '0;
            region_base  = `ROM_CPU_BASE;
            region_bank  = 2'd0;
            is_cpu       = 1'b1;
        end else if (body_kb < pcm_start) begin
            region_start = snd_start;
            region_base  = `ROM_SND_BASE;
            region_bank  = 2'd0;  // shares bank with cpu
        end else if (body_kb < gfx_start) begin
            region_start = pcm_start;
            region_base  = `ROM_PCM_BASE;
            region_bank  = 2'd1;
        end else begin
            region_start = gfx_start;
            region_base  = `ROM_GFX_BASE;
            region_bank  = 2'd2;
        end
    end

    assign rel_off = body_off - {region_start, 10'd0};

    // rotate left by one, then key xor
    always_comb begin
        if (is_cpu && decrypt)
            dec_byte = {ioctl_dout[6:0], ioctl_dout[7]} ^ `ROM_DECRYPT_KEY;
        else
            dec_byte = ioctl_dout;
    end

    // control state
    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_we    <= 1'b0;
            push      <= 1'b0;
            snd_start <= '0;
            pcm_start <= '0;
            gfx_start <= '0;
            decrypt   <= 1'b0;
        end else begin
            cfg_we <= wr_strobe && is_cfg;
            push   <= wr_strobe && is_body;
            if (wr_strobe && is_start) begin
                // byte 0 ends up in snd_start[7:0] after six writes
                {gfx_start, pcm_start, snd_start} <=
                    {ioctl_dout, gfx_start, pcm_start, snd_start[15:8]};
            end
            if (wr_strobe && ioctl_addr == `ROM_CFG_BYTE)
                decrypt <= ioctl_dout[7];
            if (!downloading)
                decrypt <= 1'b0;  // next image starts plain
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (wr_strobe && is_cfg) begin
            cfg_addr <= cfg_index[4:0];
            cfg_data <= ioctl_dout;
        end
        if (wr_strobe && is_body) begin
            req.addr <= rel_off[23:1] + region_base;  // word address
            req.data <= dec_byte;
            req.mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
            req.bank <= region_bank;
        end
    end

    // start table and config bytes must never reach the sdram side
    a_no_push_after_header: assert property (
        @(posedge clk) disable iff (reset)
        (wr_strobe && (is_start || is_cfg)) |=> !push
    ) else $error("push after header byte");

    a_cfg_push_excl: assert property (
        @(posedge clk) disable iff (reset)
        !(cfg_we && push)
    ) else $error("cfg_we and push high together");

endmodule

// File: rtl/prog_req_fifo.sv
// request fifo between region mapper and sdram writer, with sticky overflow
`timescale 1ns/1ns

`include "rom_load_cfg.svh"

module prog_req_fifo
    import rom_load_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      push,
    input  prog_req_t req,
    input  logic      pop,
    output prog_req_t head,
    output logic      empty,
    output logic      full,
    output logic      overflow
);

    localparam int unsigned AW = $clog2(`PROG_FIFO_DEPTH);
    localparam logic [AW:0] DEPTH_CNT = (AW+1)'(`PROG_FIFO_DEPTH);

    prog_req_t     mem [`PROG_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic          wr_en;
    logic          rd_en;

    assign empty = count == '0;
    assign full  = count == DEPTH_CNT;
    assign wr_en = push && !full;   // dropped when full
    assign rd_en = pop && !empty;
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (wr_en)
                wr_ptr <= wr_ptr + 1'b1;  // power of two depth wraps
            if (rd_en)
                rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            if (push && full)
                overflow <= 1'b1;  // held until reset
        end
    end

    // storage
    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= req;
    end

    a_no_pop_empty: assert property (
        @(posedge clk) disable iff (reset)
        pop |-> !empty
    ) else $error("pop while fifo empty");

endmodule

// File: rtl/sdram_prog_writer.sv
// sdram programming writer: takes queued requests and holds each write until prog_rdy
`timescale 1ns/1ns

module sdram_prog_writer
    import rom_load_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  prog_req_t   head,
    input  logic        empty,
    input  logic        prog_rdy,
    output logic        pop,
    output prog_addr_t  prog_addr,
    output logic [15:0] prog_data,
    output mask_t       prog_mask,
    output bank_t       prog_ba,
    output logic        prog_we
);

    wr_state_e state;
    wr_state_e state_nxt;
    prog_req_t cur_req;     // write in flight

    // take the head on the same edge the fifo drops it
    assign pop = state == WR_IDLE && !empty;

    always_comb begin
        state_nxt = state;
        case (state)
            WR_IDLE: begin
                if (!empty)
                    state_nxt = WR_WAIT;
            end
            WR_WAIT: begin
                if (prog_rdy)
                    state_nxt = WR_IDLE;  // one idle cycle between writes
            end
            default: state_nxt = WR_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset)
            state <= WR_IDLE;
        else
            state <= state_nxt;
    end

    always_ff @(posedge clk) begin
        if (pop)
            cur_req <= head;
    end

    assign prog_we   = state == WR_WAIT;
    assign prog_addr = cur_req.addr;
    assign prog_data = {2{cur_req.data}};  // same byte on both lanes, mask picks one
    assign prog_mask = cur_req.mask;
    assign prog_ba   = cur_req.bank;

    // sdram side samples the fields any time before prog_rdy
    a_hold_until_rdy: assert property (
        @(posedge clk) disable iff (reset)
        (prog_we && !prog_rdy) |=>
            (prog_we && $stable(prog_addr) && $stable(prog_data) &&
             $stable(prog_mask) && $stable(prog_ba))
    ) else $error("prog_we fields changed before prog_rdy");

endmodule

// File: rtl/rom_loader_top.sv
// rom loader top: region mapper feeding the sdram writer through the request fifo
`timescale 1ns/1ns

module rom_loader_top
    import rom_load_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_dout,
    input  logic        ioctl_wr,
    input  logic        prog_rdy,
    output logic        cfg_we,
    output cfg_addr_t   cfg_addr,
    output byte_t       cfg_data,
    output prog_addr_t  prog_addr,
    output logic [15:0] prog_data,
    output mask_t       prog_mask,
    output bank_t       prog_ba,
    output logic        prog_we,
    output logic        overflow
);

    logic      push;
    logic      pop;
    logic      empty;
    prog_req_t req;
    prog_req_t head;

    rom_region_mapper mapper_i (
        .clk(clk), .reset(reset), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
        .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .push(push), .req(req)
    );

    prog_req_fifo fifo_i (
        .clk(clk), .reset(reset), .push(push), .req(req), .pop(pop),
        .head(head), .empty(empty), .full(), .overflow(overflow)
    );

    sdram_prog_writer writer_i (
        .clk(clk), .reset(reset), .head(head), .empty(empty), .prog_rdy(prog_rdy),
        .pop(pop), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_mask(prog_mask), .prog_ba(prog_ba), .prog_we(prog_we)
    );

endmodule

// File: sim/rom_loader_tb.sv
// rom loader testbench: random images streamed through the loader, checked against a model
`timescale 1ns/1ns

`include "rom_load_cfg.svh"

module rom_loader_tb
    import rom_load_pkg::*;
();

    logic        clk;
    logic        reset;
    logic        downloading;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_dout;
    logic        ioctl_wr;
    logic        prog_rdy;
    logic        cfg_we;
    cfg_addr_t   cfg_addr;
    byte_t       cfg_data;
    prog_addr_t  prog_addr;
    logic [15:0] prog_data;
    mask_t       prog_mask;
    bank_t       prog_ba;
    logic        prog_we;
    logic        overflow;

    integer      seed = 32'h767b_43a6;

    // expected results, filled as bytes are sent
    prog_req_t   exp_req[$];
    cfg_addr_t   exp_cfg_addr[$];
    byte_t       exp_cfg_data[$];
    ioctl_addr_t img_addr[$];
    byte_t       img_data[$];

    // model view of the header
    kb_start_t   m_snd;
    kb_start_t   m_pcm;
    kb_start_t   m_gfx;
    logic        m_dec = 1'b0;

    int          errors = 0;
    int          pass_cnt = 0;
    int          fail_cnt = 0;
    int          cfg_seen = 0;
    int          cycle_cnt = 0;
    int          cycle_limit = 200;
    int          rdy_min = 0;
    int          rdy_max = 6;
    int          wait_left = -1;
    logic        rdy_stall = 1'b0;
    logic        hold_valid = 1'b0;

    rom_loader_top dut_i (
        .clk(clk), .reset(reset), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_dout(ioctl_dout), .ioctl_wr(ioctl_wr),
        .prog_rdy(prog_rdy), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_data(cfg_data),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_mask(prog_mask),
        .prog_ba(prog_ba), .prog_we(prog_we), .overflow(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int rand_range(input int lo, input int hi);
        rand_range = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    task automatic note_failure(input string msg);
        $display("error: %s", msg);
        errors++;
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            $display("Mismatch %s: expected %h got %h", name, exp, got);
            errors++;
        end
    endtask

    task automatic check_cfg(input cfg_addr_t exp_addr, input byte_t exp_data);
        if (cfg_addr !== exp_addr) begin
            $display("Mismatch cfg_addr: expected %h got %h", exp_addr, cfg_addr);
            errors++;
        end
        if (cfg_data !== exp_data) begin
            $display("Mismatch cfg_data: expected %h got %h", exp_data, cfg_data);
            errors++;
        end
    endtask

    task automatic check_req(input prog_req_t exp);
        if (prog_addr !== exp.addr) begin
            $display("Mismatch prog_addr: expected %h got %h", exp.addr, prog_addr);
            errors++;
        end
        if (prog_data !== {exp.data, exp.data}) begin
            $display("Mismatch prog_data: expected %h got %h", {exp.data, exp.data}, prog_data);
            errors++;
        end
        if (prog_mask !== exp.mask) begin
            $display("Mismatch prog_mask: expected %h got %h", exp.mask, prog_mask);
            errors++;
        end
        if (prog_ba !== exp.bank) begin
            $display("Mismatch prog_ba: expected %h got %h", exp.bank, prog_ba);
            errors++;
        end
    endtask

    // reference model, one host byte at a time
    task automatic model_byte(input ioctl_addr_t a, input byte_t d);
        int unsigned b;
        int unsigned kb;
        int unsigned rstart;
        prog_addr_t  base;
        bank_t       bk;
        logic        cpu;
        prog_req_t   r;
        case (a)
            0: m_snd[7:0]  = d;
            1: m_snd[15:8] = d;
            2: m_pcm[7:0]  = d;
            3: m_pcm[15:8] = d;
            4: m_gfx[7:0]  = d;
            5: m_gfx[15:8] = d;
            default: ;
        endcase
        if (a >= `ROM_CFG_FIRST && a <= `ROM_CFG_LAST) begin
            exp_cfg_addr.push_back(cfg_addr_t'(a - `ROM_CFG_FIRST));
            exp_cfg_data.push_back(d);
        end
        if (a == `ROM_CFG_BYTE)
            m_dec = d[7];
        if (a >= `ROM_HEADER_LEN) begin
            b   = a - `ROM_HEADER_LEN;
            kb  = b / 1024;
            cpu = 1'b0;
            if (kb < m_snd) begin
                rstart = 0;
                base   = `ROM_CPU_BASE;
                bk     = 2'd0;
                cpu    = 1'b1;
            end else if (kb < m_pcm) begin
                rstart = m_snd;
                base   = `ROM_SND_BASE;
                bk     = 2'd0;
            end else if (kb < m_gfx) begin
                rstart = m_pcm;
                base   = `ROM_PCM_BASE;
                bk     = 2'd1;
            end else begin
                rstart = m_gfx;
                base   = `ROM_GFX_BASE;
                bk     = 2'd2;
            end
            r.addr = prog_addr_t'((b - rstart * 1024) / 2) + base;
            r.data = (cpu && m_dec) ? ({d[6:0], d[7]} ^ `ROM_DECRYPT_KEY) : d;
            r.mask = a[0] ? 2'b01 : 2'b10;  // odd byte on the upper lane
            r.bank = bk;
            exp_req.push_back(r);
        end
    endtask

    task automatic add_body(input int b);
        img_addr.push_back(ioctl_addr_t'(b + `ROM_HEADER_LEN));
        img_data.push_back(byte_t'($random(seed)));
    endtask

    // dec_sel 0 or 1 forces the decrypt bit, 2 leaves it random
    task automatic build_image(input int dec_sel, input int n_rand);
        int    st [4];
        int    kb_end;
        byte_t hdr [`ROM_HEADER_LEN];
        int    lo;
        int    hi;
        int    r;
        int    i;
        img_addr.delete();
        img_data.delete();
        st[0] = 0;
        for (r = 1; r < 4; r++)
            st[r] = st[r-1] + rand_range(1, 3);
        kb_end = st[3] + rand_range(1, 3);
        for (i = 0; i < `ROM_HEADER_LEN; i++)
            hdr[i] = byte_t'($random(seed));
        for (i = 0; i < 3; i++) begin
            hdr[2*i]   = st[i+1][7:0];
            hdr[2*i+1] = st[i+1][15:8];
        end
        if (dec_sel < 2)
            hdr[`ROM_CFG_BYTE][7] = dec_sel[0];
        for (i = 0; i < `ROM_HEADER_LEN; i++) begin
            img_addr.push_back(ioctl_addr_t'(i));
            img_data.push_back(hdr[i]);
        end
        if (n_rand > 0) begin
            for (r = 0; r < 4; r++) begin
                lo = st[r] * 1024;
                hi = ((r == 3) ? kb_end : st[r+1]) * 1024 - 1;
                add_body(lo);
                add_body(lo + 1);
                repeat (n_rand) add_body(lo + rand_range(0, hi - lo));
                add_body(hi - 1);
                add_body(hi);  // last byte before the next region
            end
        end
    endtask

    task automatic wait_slot();
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int n);
        repeat (n) wait_slot();
    endtask

    task automatic strobe(input ioctl_addr_t a, input byte_t d);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        wait_slot();
        ioctl_wr   = 1'b0;
    endtask

    task automatic send_queue();
        int i;
        cycle_limit += 16 * img_addr.size();
        for (i = 0; i < img_addr.size(); i++) begin
            // host keeps at most six writes outstanding
            if (img_addr[i] >= `ROM_HEADER_LEN)
                while (exp_req.size() >= 6) wait_slot();
            model_byte(img_addr[i], img_data[i]);
            strobe(img_addr[i], img_data[i]);
            idle(rand_range(2, 5) - 1);
        end
    endtask

    task automatic start_download();
        wait_slot();
        downloading = 1'b1;
        wait_slot();
    endtask

    task automatic end_download();
        while (exp_req.size() != 0 || exp_cfg_addr.size() != 0)
            wait_slot();
        wait_slot();
        downloading = 1'b0;
        m_dec       = 1'b0;  // flag drops with downloading
        wait_slot();
    endtask

    task automatic finish_test(input int num, input string name, input int err0);
        if (errors == err0) begin
            pass_cnt++;
            $display("test %0d %s: pass", num, name);
        end else begin
            fail_cnt++;
            $display("test %0d %s: FAIL (%0d errors)", num, name, errors - err0);
        end
    endtask

    task automatic run_download(input int num, input string name, input int dec_sel,
                                input int dmin, input int dmax);
        int err0;
        err0    = errors;
        rdy_min = dmin;
        rdy_max = dmax;
        build_image(dec_sel, 6);
        cfg_seen = 0;
        start_download();
        send_queue();
        end_download();
        if (cfg_seen != `ROM_CFG_LAST - `ROM_CFG_FIRST + 1)
            note_failure($sformatf("expected 32 config writes, saw %0d", cfg_seen));
        check_flag("overflow", 1'b0, overflow);
        finish_test(num, name, err0);
    endtask

    // back to back body bytes with the sdram stalled
    task automatic run_overflow_burst(input int num, input string name);
        int          err0;
        int          i;
        ioctl_addr_t a;
        byte_t       d;
        err0    = errors;
        rdy_min = 0;
        rdy_max = 6;
        build_image(0, 0);
        start_download();
        send_queue();
        rdy_stall = 1'b1;
        cycle_limit += 16 * 12;
        for (i = 0; i < 12; i++) begin
            a = ioctl_addr_t'(`ROM_HEADER_LEN + i);
            d = byte_t'($random(seed));
            if (i < `PROG_FIFO_DEPTH + 1)
                model_byte(a, d);  // fifo entries plus the write held by the writer
            ioctl_addr = a;
            ioctl_dout = d;
            ioctl_wr   = 1'b1;
            wait_slot();
        end
        ioctl_wr = 1'b0;
        idle(3);
        check_flag("overflow", 1'b1, overflow);
        rdy_stall = 1'b0;
        end_download();
        finish_test(num, name, err0);
    endtask

    // sdram side, acks each write after a random delay
    initial begin
        prog_rdy = 1'b0;
        forever begin
            wait_slot();
            if (prog_rdy) begin
                prog_rdy  = 1'b0;  // writer leaves WR_WAIT on this edge
                wait_left = -1;
            end else if (prog_we === 1'b1 && !rdy_stall) begin
                if (wait_left < 0)
                    wait_left = rand_range(rdy_min, rdy_max);
                if (wait_left == 0)
                    prog_rdy = 1'b1;
                else
                    wait_left--;
            end
        end
    end

    // outputs are sampled mid cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (cfg_we === 1'b1) begin
                cfg_seen++;
                if (exp_cfg_addr.size() == 0)
                    note_failure("cfg_we with no config write expected");
                else
                    check_cfg(exp_cfg_addr.pop_front(), exp_cfg_data.pop_front());
            end
            if (hold_valid && prog_we !== 1'b1)
                note_failure("prog_we dropped before prog_rdy");
            if (prog_we === 1'b1) begin
                if (exp_req.size() == 0)
                    note_failure("sdram write with no request expected");
                else if (prog_rdy)
                    check_req(exp_req.pop_front());
                else
                    check_req(exp_req[0]);  // held write already matches the oldest request
            end
            hold_valid = prog_we === 1'b1 && !prog_rdy;
        end
    end

    initial begin
        while (cycle_cnt <= cycle_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("timeout: run still busy after %0d cycles", cycle_limit);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        reset = 1'b0;

        run_download(1, "download with random decrypt bit", 2, 0, 6);
        run_download(2, "cpu decryption on", 1, 0, 6);
        run_download(3, "second download plain", 0, 0, 6);
        run_download(4, "slow prog_rdy", 0, 4, 6);
        run_overflow_burst(5, "overflow burst");

        $display("tests passed: %0d  failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+include
rtl/rom_load_pkg.sv
rtl/rom_region_mapper.sv
rtl/prog_req_fifo.sv
rtl/sdram_prog_writer.sv
rtl/rom_loader_top.sv
sim/rom_loader_tb.sv

// File: Bender.yml
package:
  name: rom_loader

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/rom_load_pkg.sv
      - rtl/rom_region_mapper.sv
      - rtl/prog_req_fifo.sv
      - rtl/sdram_prog_writer.sv
      - rtl/rom_loader_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/rom_loader_tb.sv
